/* Makefile */
VERILATOR ?= verilator
TOP       ?= mshr_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# pass only if the pass line shows up in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* bench/mshr_memory_model.sv */
`default_nettype none

module mshr_memory_model
  import mshr_pkg::*;
#(
  parameter logic [31:0] seed     = 32'h5f59_d5e5,
  parameter data_t       data_key = 64'h0
) (
  input  wire          clock,
  input  wire          reset,
  input  logic         stall,
  input  mem_request_t mem_request,
  output mem_tag_t     mem_response,
  output mem_tag_t     mem_return_tag,
  output data_t        mem_return_data
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lfsr_state = seed;
  logic [15:0] tag_busy;
  logic [15:0] return_pending;
  addr_t       return_addr [16];
  logic [3:0]  return_wait [16];
  logic [2:0]  accept_wait;
  mem_tag_t    next_tag;
  mem_tag_t    free_tag;
  logic        returned;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // rotate through 1..15, skip tags still out
  function automatic mem_tag_t pick_tag(input mem_tag_t start, input logic [15:0] busy);
    mem_tag_t tag;
    tag = start;
    for (int i = 0; i < 15; i++) begin
      if (!busy[tag]) begin
        return tag;
      end
      tag = (tag == 4'd15) ? 4'd1 : tag + 4'd1;
    end
    return '0;
  endfunction

  initial begin
    mem_response    <= '0;
    mem_return_tag  <= '0;
    mem_return_data <= '0;
  end

  always @(posedge clock) begin
    if (reset) begin
      mem_response   <= '0;
      mem_return_tag <= '0;
      tag_busy       = '0;
      return_pending = '0;
      accept_wait    = '0;
      next_tag       = 4'd1;
    end else begin
      mem_return_tag <= '0;
      returned = 1'b0;
      // one return per cycle, lowest expired tag first
      for (int t = 1; t < 16; t++) begin
        if (return_pending[t]) begin
          if (return_wait[t] != '0) begin
            return_wait[t] = return_wait[t] - 4'd1;
          end else if (!returned && !stall) begin
            returned = 1'b1;
            mem_return_tag  <= mem_tag_t'(t);
            mem_return_data <= {return_addr[t][31:0], return_addr[t][63:32]} ^ data_key;
            return_pending[t] = 1'b0;
            tag_busy[t] = 1'b0;
          end
        end
      end
      if (mem_response != '0) begin
        // taken at this edge; stores expect nothing back
        if (mem_request.command == BUS_LOAD) begin
          return_pending[mem_response] = 1'b1;
          return_addr[mem_response] = mem_request.addr;
          return_wait[mem_response] = 4'(random_bits(4));
        end else begin
          tag_busy[mem_response] = 1'b0;
        end
        mem_response <= '0;
      end else if (mem_request.command != BUS_NONE && !stall) begin
        if (accept_wait != '0) begin
          accept_wait = accept_wait - 3'd1;
        end else begin
          free_tag = pick_tag(next_tag, tag_busy);
          if (free_tag != '0) begin
            tag_busy[free_tag] = 1'b1;
            next_tag = (free_tag == 4'd15) ? 4'd1 : free_tag + 4'd1;
            mem_response <= free_tag;
            accept_wait = 3'(random_bits(3));
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/mshr_tb.sv */
`default_nettype none

module mshr_tb
  import mshr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth      = 8;
  localparam int miss_count = 200;
  // worst accept plus return delay of the memory model in cycles
  localparam int max_mem_delay = 24;
  localparam longint watchdog_ns = longint'(miss_count + depth) * max_mem_delay * 8 * 40;
  localparam logic [31:0] seed = 32'h5f59_d5e5;
  localparam data_t fill_key   = 64'h9e37_79b9_7f4a_7c15;
  localparam addr_t pool_base  = 64'h0000_0000_0004_0000;
  localparam addr_t stall_base = 64'h0000_0000_0008_0000;

  logic          clock;
  logic          reset;
  logic          stall;
  logic          miss_valid;
  miss_request_t miss;
  logic          miss_ready;
  mem_request_t  mem_request;
  mem_tag_t      mem_response;
  mem_tag_t      mem_return_tag;
  data_t         mem_return_data;
  logic          fill_valid;
  fill_t         fill;

  logic [31:0]  lfsr_state = seed;
  mem_request_t request_queue[$];
  fill_t        fill_queue[$];
  int           absorbed_count = 0;

  mshr #(.depth(depth)) mshr_i (
    .clock           (clock),
    .reset           (reset),
    .miss_valid      (miss_valid),
    .miss            (miss),
    .miss_ready      (miss_ready),
    .mem_request     (mem_request),
    .mem_response    (mem_response),
    .mem_return_tag  (mem_return_tag),
    .mem_return_data (mem_return_data),
    .fill_valid      (fill_valid),
    .fill            (fill)
  );

  mshr_memory_model #(.seed(seed), .data_key(fill_key)) memory_i (
    .clock           (clock),
    .reset           (reset),
    .stall           (stall),
    .mem_request     (mem_request),
    .mem_response    (mem_response),
    .mem_return_tag  (mem_return_tag),
    .mem_return_data (mem_return_data)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // memory returns each address with its halves swapped and xored with a key
  function automatic data_t expected_fill_data(input addr_t addr);
    return {addr[31:0], addr[63:32]} ^ fill_key;
  endfunction

  function automatic logic load_pending(input addr_t addr);
    foreach (fill_queue[i]) begin
      if (fill_queue[i].addr == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      fail_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, expected));
    end
  endtask

  task automatic check_command(input bus_command_t got, input bus_command_t expected);
    if (got !== expected) begin
      fail_run($sformatf("** Error at %0t: request command %0d, expected %0d",
                         $time, got, expected));
    end
  endtask

  task automatic check_request(input mem_request_t got, input mem_request_t expected);
    if (got !== expected) begin
      fail_run($sformatf("** Error at %0t: request %0d/%h/%h, expected %0d/%h/%h", $time,
                         got.command, got.addr, got.data,
                         expected.command, expected.addr, expected.data));
    end
  endtask

  task automatic check_fill(input fill_t got, input fill_t expected);
    if (got !== expected) begin
      fail_run($sformatf("** Error at %0t: fill %h/%h, expected %h/%h", $time,
                         got.addr, got.data, expected.addr, expected.data));
    end
  endtask

  task automatic drive_miss(input bus_command_t command, input addr_t addr, input data_t data);
    @(posedge clock);
    miss_valid <= 1'b1;
    miss <= '{command: command, addr: addr, data: data};
  endtask

  // returns just before the accepting edge
  task automatic send_miss(input bus_command_t command, input addr_t addr, input data_t data);
    drive_miss(command, addr, data);
    @(negedge clock);
    while (!miss_ready) begin
      @(negedge clock);
    end
  endtask

  task automatic idle(input int cycles);
    @(posedge clock);
    miss_valid <= 1'b0;
    repeat (cycles - 1) @(posedge clock);
  endtask

  // everything seen here takes effect at the next rising edge
  always @(negedge clock) begin
    mem_request_t expected_request;
    fill_t        expected_fill;
    if (!reset) begin
      if (miss_valid && miss_ready) begin
        if (miss.command == BUS_LOAD && load_pending(miss.addr)) begin
          absorbed_count++;
        end else begin
          expected_request = '{command: miss.command, addr: miss.addr, data: miss.data};
          request_queue.push_back(expected_request);
          if (miss.command == BUS_LOAD) begin
            expected_fill = '{addr: miss.addr, data: expected_fill_data(miss.addr)};
            fill_queue.push_back(expected_fill);
          end
        end
      end
      if (mem_request.command != BUS_NONE) begin
        if (request_queue.size() == 0) begin
          fail_run("memory request seen with no miss left to issue");
        end else if (mem_response != '0) begin
          check_request(mem_request, request_queue.pop_front());
        end
      end
      if (fill_valid) begin
        if (fill_queue.size() == 0) begin
          fail_run("fill seen with no load left to fill");
        end else begin
          check_fill(fill, fill_queue.pop_front());
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    fail_run($sformatf("watchdog expired with %0d requests and %0d fills still owed",
                       request_queue.size(), fill_queue.size()));
  end

  initial begin
    bus_command_t command;
    addr_t        addr;
    data_t        data;
    int           gap;
    clock = 1'b0;
    reset <= 1'b1;
    stall <= 1'b0;
    miss_valid <= 1'b0;
    miss <= '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    check_flag(miss_ready, 1'b1, "miss_ready after reset");
    check_flag(fill_valid, 1'b0, "fill_valid after reset");
    check_command(mem_request.command, BUS_NONE);

    // with memory stalled the table fills up and pushes back
    @(posedge clock);
    stall <= 1'b1;
    for (int i = 0; i < depth; i++) begin
      command = i[0] ? BUS_STORE : BUS_LOAD;
      data = i[0] ? {random_bits(32), random_bits(32)} : '0;
      drive_miss(command, stall_base + addr_t'(i) * 64, data);
      @(negedge clock);
      check_flag(miss_ready, 1'b1, "miss_ready before the table is full");
    end
    idle(1);
    @(negedge clock);
    check_flag(miss_ready, 1'b0, "miss_ready with the table full");
    @(posedge clock);
    stall <= 1'b0;
    @(negedge clock);
    while (!miss_ready) begin
      @(negedge clock);
    end
    // the first slot frees only once the oldest load has filled
    if (fill_queue.size() != depth / 2 - 1) begin
      fail_run("miss_ready rose again before the oldest load was filled");
    end

    // small address pool so loads hit pending lines
    for (int n = 0; n < miss_count; n++) begin
      addr = pool_base + addr_t'(random_bits(3)) * 64;
      command = (random_bits(2) == 0) ? BUS_STORE : BUS_LOAD;
      data = (command == BUS_STORE) ? {random_bits(32), random_bits(32)} : '0;
      send_miss(command, addr, data);
      gap = int'(random_bits(2));
      if (gap != 0) begin
        idle(gap);
      end
    end
    idle(1);

    while (request_queue.size() != 0 || fill_queue.size() != 0) begin
      @(negedge clock);
    end
    repeat (20) @(negedge clock);
    if (absorbed_count == 0) begin
      fail_run("stimulus produced no absorbed load");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
source/mshr_pkg.sv
source/mshr_table.sv
source/mshr_issue.sv
source/mshr_retire.sv
source/mshr.sv
bench/mshr_memory_model.sv
bench/mshr_tb.sv

/* source/mshr.sv */
`default_nettype none

module mshr
  import mshr_pkg::*;
#(
  parameter int depth = 8
) (
  input  wire           clock,
  input  wire           reset,
  input  logic          miss_valid,
  input  miss_request_t miss,
  output logic          miss_ready,
  output mem_request_t  mem_request,
  input  mem_tag_t      mem_response,
  input  mem_tag_t      mem_return_tag,
  input  data_t         mem_return_data,
  output logic          fill_valid,
  output fill_t         fill
);

  mshr_entry_t [depth-1:0]  entries;
  logic                     issue_accept;
  logic [$clog2(depth)-1:0] issue_index;
  logic                     retire_free;
  logic [$clog2(depth)-1:0] retire_index;

  mshr_table #(.depth(depth)) table_i (
    .clock           (clock),
    .reset           (reset),
    .miss_valid      (miss_valid),
    .miss            (miss),
    .miss_ready      (miss_ready),
    .issue_accept    (issue_accept),
    .issue_index     (issue_index),
    .mem_response    (mem_response),
    .mem_return_tag  (mem_return_tag),
    .mem_return_data (mem_return_data),
    .retire_free     (retire_free),
    .retire_index    (retire_index),
    .entries         (entries)
  );

  mshr_issue #(.depth(depth)) issue_i (
    .clock        (clock),
    .reset        (reset),
    .entries      (entries),
    .mem_response (mem_response),
    .mem_request  (mem_request),
    .issue_accept (issue_accept),
    .issue_index  (issue_index)
  );

  mshr_retire #(.depth(depth)) retire_i (
    .clock        (clock),
    .reset        (reset),
    .entries      (entries),
    .fill_valid   (fill_valid),
    .fill         (fill),
    .retire_free  (retire_free),
    .retire_index (retire_index)
  );

endmodule

`default_nettype wire

/* source/mshr_issue.sv */
`default_nettype none

module mshr_issue
  import mshr_pkg::*;
#(
  parameter int depth = 8
) (
  input  wire                               clock,
  input  wire                               reset,
  input  mshr_entry_t [depth-1:0]           entries,
  input  mem_tag_t                          mem_response,
  output mem_request_t                      mem_request,
  output logic                              issue_accept,
  output logic [$clog2(depth)-1:0]          issue_index
);

  localparam int index_width = $clog2(depth);

  typedef logic [index_width-1:0] index_t;

  index_t      issue_ptr;
  mshr_entry_t head_entry;
  logic        waiting;

  assign head_entry = entries[issue_ptr];
  assign waiting    = head_entry.valid && head_entry.state == WAITING;

  assign mem_request.command = waiting ? head_entry.command : BUS_NONE;
  assign mem_request.addr    = head_entry.addr;
  assign mem_request.data    = head_entry.data;

  // a nonzero response is the accept
  assign issue_accept = waiting && mem_response != '0;
  assign issue_index  = issue_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (issue_accept) begin
      issue_ptr <= issue_ptr + 1'b1;
    end
  end

  // back-pressured request must hold until memory takes it
  assert property (@(posedge clock) disable iff (reset)
    (mem_request.command != BUS_NONE && mem_response == '0) |=> $stable(mem_request));

endmodule

`default_nettype wire

/* source/mshr_pkg.sv */
`default_nettype none

package mshr_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;

  // zero means no tag
  typedef logic [3:0] mem_tag_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  typedef enum logic [1:0] {
    WAITING    = 2'h0,
    INPROGRESS = 2'h1,
    DONE       = 2'h2
  } entry_state_t;

  typedef struct packed {
    bus_command_t command;
    addr_t        addr;
    data_t        data;
  } miss_request_t;

  typedef struct packed {
    logic         valid;
    entry_state_t state;
    bus_command_t command;
    addr_t        addr;
    data_t        data;
    mem_tag_t     mem_tag;
  } mshr_entry_t;

  typedef struct packed {
    bus_command_t command;
    addr_t        addr;
    data_t        data;
  } mem_request_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } fill_t;

endpackage

`default_nettype wire

/* source/mshr_retire.sv */
`default_nettype none

module mshr_retire
  import mshr_pkg::*;
#(
  parameter int depth = 8
) (
  input  wire                               clock,
  input  wire                               reset,
  input  mshr_entry_t [depth-1:0]           entries,
  output logic                              fill_valid,
  output fill_t                             fill,
  output logic                              retire_free,
  output logic [$clog2(depth)-1:0]          retire_index
);

  localparam int index_width = $clog2(depth);

  typedef logic [index_width-1:0] index_t;

  index_t      wb_ptr;
  mshr_entry_t wb_entry;
  logic        wb_done;

  assign wb_entry = entries[wb_ptr];
  assign wb_done  = wb_entry.valid && wb_entry.state == DONE;

  // only loads go back to the cache, stores just drop out
  assign fill_valid = wb_done && wb_entry.command == BUS_LOAD;
  assign fill.addr  = wb_entry.addr;
  assign fill.data  = wb_entry.data;

  assign retire_free  = wb_done;
  assign retire_index = wb_ptr;

  // in order, a later done entry waits behind an older one
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_ptr <= '0;
    end else if (wb_done) begin
      wb_ptr <= wb_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/mshr_table.sv */
`default_nettype none

module mshr_table
  import mshr_pkg::*;
#(
  parameter int depth = 8
) (
  input  wire                               clock,
  input  wire                               reset,
  input  logic                              miss_valid,
  input  miss_request_t                     miss,
  output logic                              miss_ready,
  input  logic                              issue_accept,
  input  logic [$clog2(depth)-1:0]          issue_index,
  input  mem_tag_t                          mem_response,
  input  mem_tag_t                          mem_return_tag,
  input  data_t                             mem_return_data,
  input  logic                              retire_free,
  input  logic [$clog2(depth)-1:0]          retire_index,
  output mshr_entry_t [depth-1:0]           entries
);

  localparam int index_width = $clog2(depth);

  typedef logic [index_width-1:0] index_t;
  typedef logic [index_width:0]   count_t;

  localparam count_t full_count = count_t'(depth);

  index_t           tail;
  count_t           count;
  logic             load_hit;
  logic             allocate;
  logic [depth-1:0] in_flight;
  logic             tag_clash;

  assign miss_ready = (count != full_count);

  // a load already pending as a load needs no second request
  always_comb begin
    load_hit = 1'b0;
    for (int i = 0; i < depth; i++) begin
      if (entries[i].valid && entries[i].command == BUS_LOAD &&
          entries[i].addr == miss.addr) begin
        load_hit = 1'b1;
      end
    end
  end

  assign allocate = miss_valid && miss_ready && !(miss.command == BUS_LOAD && load_hit);

  always_ff @(posedge clock) begin
    if (reset) begin
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < depth; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].state <= WAITING;
      end
    end else begin
      count <= count + count_t'(allocate) - count_t'(retire_free);

      // accepted by memory, stores need nothing back
      if (issue_accept) begin
        entries[issue_index].mem_tag <= mem_response;
        if (entries[issue_index].command == BUS_STORE) begin
          entries[issue_index].state <= DONE;
        end else begin
          entries[issue_index].state <= INPROGRESS;
        end
      end

      for (int i = 0; i < depth; i++) begin
        if (entries[i].valid && entries[i].state == INPROGRESS &&
            mem_return_tag != '0 && entries[i].mem_tag == mem_return_tag) begin
          entries[i].state <= DONE;
          entries[i].data  <= mem_return_data;
        end
      end

      if (retire_free) begin
        entries[retire_index].valid <= 1'b0;
      end

      if (allocate) begin
        entries[tail] <= '{
          valid:   1'b1,
          state:   WAITING,
          command: miss.command,
          addr:    miss.addr,
          data:    miss.data,
          mem_tag: '0
        };
        tail <= tail + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      in_flight[i] = entries[i].valid && entries[i].state == INPROGRESS &&
                     entries[i].mem_tag != '0;
    end
  end

  always_comb begin
    tag_clash = 1'b0;
    for (int i = 0; i < depth; i++) begin
      for (int j = i + 1; j < depth; j++) begin
        if (in_flight[i] && in_flight[j] && entries[i].mem_tag == entries[j].mem_tag) begin
          tag_clash = 1'b1;
        end
      end
    end
  end

  // occupancy count must agree with what retirement has freed
  assert property (@(posedge clock) disable iff (reset)
    allocate |-> !entries[tail].valid);

  // memory must never reuse a tag still outstanding
  assert property (@(posedge clock) disable iff (reset)
    !tag_clash);

endmodule

`default_nettype wire
